/* Bender.yml */
package:
  name: looper_backend

sources:
  - hw/looper_pkg.sv
  - hw/phys_reg_file.sv
  - hw/operand_read.sv
  - hw/alu_lane.sv
  - hw/writeback.sv
  - hw/looper_backend.sv
  - target: test
    files:
      - sim/looper_backend_tb.sv

/* hw/alu_lane.sv */
`timescale 1ns/1ns

module alu_lane import looper_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      stall,
   input  logic      op_vld,
   input  data_t     op_a,
   input  data_t     op_b,
   input  alu_mode_t op_mode,
   input  preg_t     op_dst,
   input  logic      op_reg_wrt,
   input  rob_idx_t  op_idx,
   output logic      ex_vld,
   output data_t     ex_result,
   output preg_t     ex_dst,
   output logic      ex_reg_wrt,
   output rob_idx_t  ex_idx
);

   data_t alu_result;

   always_comb begin
      case (op_mode)
         MODE_ADD:  alu_result = op_a + op_b;
         MODE_SUB:  alu_result = op_a - op_b;
         MODE_AND:  alu_result = op_a & op_b;
         MODE_OR:   alu_result = op_a | op_b;
         MODE_XOR:  alu_result = op_a ^ op_b;
         // shift amount from low bits of b only
         MODE_SLL:  alu_result = op_a << op_b[SHAMT_W-1:0];
         MODE_SRL:  alu_result = op_a >> op_b[SHAMT_W-1:0];
         MODE_PASS: alu_result = op_b;
         default:   alu_result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_vld <= 1'b0;
      end else if (!stall) begin
         ex_vld <= op_vld;
      end
   end

   // result and tags travel together
   always_ff @(posedge clk) begin
      if (!stall) begin
         ex_result  <= alu_result;
         ex_dst     <= op_dst;
         ex_reg_wrt <= op_reg_wrt;
         ex_idx     <= op_idx;
      end
   end

endmodule

/* hw/looper_backend.sv */
`timescale 1ns/1ns

module looper_backend import looper_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      stall,
   input  logic      issue_vld     [NUM_LANES],
   input  alu_mode_t issue_mode    [NUM_LANES],
   input  preg_t     issue_src1    [NUM_LANES],
   input  preg_t     issue_src2    [NUM_LANES],
   input  data_t     issue_imm     [NUM_LANES],
   input  logic      issue_imm_vld [NUM_LANES],
   input  preg_t     issue_dst     [NUM_LANES],
   input  logic      issue_reg_wrt [NUM_LANES],
   input  rob_idx_t  issue_idx     [NUM_LANES],
   output logic      done_vld      [NUM_LANES],
   output rob_idx_t  done_idx      [NUM_LANES],
   output data_t     done_data     [NUM_LANES]
);

   // operand read to lanes
   logic      op_vld     [NUM_LANES];
   data_t     op_a       [NUM_LANES];
   data_t     op_b       [NUM_LANES];
   alu_mode_t op_mode    [NUM_LANES];
   preg_t     op_dst     [NUM_LANES];
   logic      op_reg_wrt [NUM_LANES];
   rob_idx_t  op_idx     [NUM_LANES];

   // lanes to writeback
   logic      ex_vld     [NUM_LANES];
   data_t     ex_result  [NUM_LANES];
   preg_t     ex_dst     [NUM_LANES];
   logic      ex_reg_wrt [NUM_LANES];
   rob_idx_t  ex_idx     [NUM_LANES];

   // writeback into the register file
   logic      wr_en      [NUM_LANES];
   preg_t     wr_preg    [NUM_LANES];
   data_t     wr_data    [NUM_LANES];

   operand_read operand_read_inst (.*);

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      alu_lane alu_lane_inst (
         .clk        (clk),
         .reset      (reset),
         .stall      (stall),
         .op_vld     (op_vld[i]),
         .op_a       (op_a[i]),
         .op_b       (op_b[i]),
         .op_mode    (op_mode[i]),
         .op_dst     (op_dst[i]),
         .op_reg_wrt (op_reg_wrt[i]),
         .op_idx     (op_idx[i]),
         .ex_vld     (ex_vld[i]),
         .ex_result  (ex_result[i]),
         .ex_dst     (ex_dst[i]),
         .ex_reg_wrt (ex_reg_wrt[i]),
         .ex_idx     (ex_idx[i])
      );
   end

   writeback writeback_inst (.*);

endmodule

/* hw/looper_pkg.sv */
package looper_pkg;

   // lane and register file geometry
   localparam int NUM_LANES  = 4;
   localparam int PREG_COUNT = 64;

   // data path and tag widths
   localparam int DATA_W    = 16;
   localparam int PREG_W    = $clog2(PREG_COUNT);
   localparam int ROB_IDX_W = 6;
   localparam int MODE_W    = 3;
   localparam int SHAMT_W   = $clog2(DATA_W);

   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [PREG_W-1:0]    preg_t;
   typedef logic [ROB_IDX_W-1:0] rob_idx_t;
   typedef logic [MODE_W-1:0]    alu_mode_t;

   // alu operation codes
   localparam alu_mode_t MODE_ADD  = 3'd0;
   localparam alu_mode_t MODE_SUB  = 3'd1;
   localparam alu_mode_t MODE_AND  = 3'd2;
   localparam alu_mode_t MODE_OR   = 3'd3;
   localparam alu_mode_t MODE_XOR  = 3'd4;
   localparam alu_mode_t MODE_SLL  = 3'd5;
   localparam alu_mode_t MODE_SRL  = 3'd6;
   // result is operand b, so load-immediate when b is the immediate
   localparam alu_mode_t MODE_PASS = 3'd7;

endpackage

/* hw/operand_read.sv */
`timescale 1ns/1ns

module operand_read import looper_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      stall,
   input  logic      issue_vld     [NUM_LANES],
   input  alu_mode_t issue_mode    [NUM_LANES],
   input  preg_t     issue_src1    [NUM_LANES],
   input  preg_t     issue_src2    [NUM_LANES],
   input  data_t     issue_imm     [NUM_LANES],
   input  logic      issue_imm_vld [NUM_LANES],
   input  preg_t     issue_dst     [NUM_LANES],
   input  logic      issue_reg_wrt [NUM_LANES],
   input  rob_idx_t  issue_idx     [NUM_LANES],
   input  logic      wr_en         [NUM_LANES],
   input  preg_t     wr_preg       [NUM_LANES],
   input  data_t     wr_data       [NUM_LANES],
   output logic      op_vld        [NUM_LANES],
   output data_t     op_a          [NUM_LANES],
   output data_t     op_b          [NUM_LANES],
   output alu_mode_t op_mode       [NUM_LANES],
   output preg_t     op_dst        [NUM_LANES],
   output logic      op_reg_wrt    [NUM_LANES],
   output rob_idx_t  op_idx        [NUM_LANES]
);

   data_t src_a_data [NUM_LANES];
   data_t src_b_data [NUM_LANES];
   data_t operand_b  [NUM_LANES];

   phys_reg_file phys_reg_file_inst (
      .clk       (clk),
      .reset     (reset),
      .rd_a_preg (issue_src1),
      .rd_b_preg (issue_src2),
      .rd_a_data (src_a_data),
      .rd_b_data (src_b_data),
      .wr_en     (wr_en),
      .wr_preg   (wr_preg),
      .wr_data   (wr_data)
   );

   // immediate replaces the second source
   always_comb begin
      for (int l = 0; l < NUM_LANES; l++) begin
         operand_b[l] = issue_imm_vld[l] ? issue_imm[l] : src_b_data[l];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            op_vld[l] <= 1'b0;
         end
      end else if (!stall) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            op_vld[l] <= issue_vld[l];
         end
      end
   end

   // packet payload, frozen while stalled
   always_ff @(posedge clk) begin
      if (!stall) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            op_a[l]       <= src_a_data[l];
            op_b[l]       <= operand_b[l];
            op_mode[l]    <= issue_mode[l];
            op_dst[l]     <= issue_dst[l];
            op_reg_wrt[l] <= issue_reg_wrt[l];
            op_idx[l]     <= issue_idx[l];
         end
      end
   end

endmodule

/* hw/phys_reg_file.sv */
`timescale 1ns/1ns

module phys_reg_file import looper_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  preg_t rd_a_preg [NUM_LANES],
   input  preg_t rd_b_preg [NUM_LANES],
   output data_t rd_a_data [NUM_LANES],
   output data_t rd_b_data [NUM_LANES],
   input  logic  wr_en     [NUM_LANES],
   input  preg_t wr_preg   [NUM_LANES],
   input  data_t wr_data   [NUM_LANES]
);

   data_t regs [PREG_COUNT];

   // stored value unless a write port targets the same register
   // this cycle; the highest lane writing wins
   function automatic data_t read_port(input preg_t preg);
      data_t value;
      value = regs[preg];
      for (int w = 0; w < NUM_LANES; w++) begin
         if (wr_en[w] && wr_preg[w] == preg) begin
            value = wr_data[w];
         end
      end
      return value;
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < PREG_COUNT; r++) begin
            regs[r] <= '0;
         end
      end else begin
         // loop order makes the higher lane win on a conflict
         for (int w = 0; w < NUM_LANES; w++) begin
            if (wr_en[w]) begin
               regs[wr_preg[w]] <= wr_data[w];
            end
         end
      end
   end

   // two read ports per lane
   always_comb begin
      for (int l = 0; l < NUM_LANES; l++) begin
         rd_a_data[l] = read_port(rd_a_preg[l]);
         rd_b_data[l] = read_port(rd_b_preg[l]);
      end
   end

endmodule

/* hw/writeback.sv */
`timescale 1ns/1ns

module writeback import looper_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall,
   input  logic     ex_vld     [NUM_LANES],
   input  data_t    ex_result  [NUM_LANES],
   input  preg_t    ex_dst     [NUM_LANES],
   input  logic     ex_reg_wrt [NUM_LANES],
   input  rob_idx_t ex_idx     [NUM_LANES],
   output logic     wr_en      [NUM_LANES],
   output preg_t    wr_preg    [NUM_LANES],
   output data_t    wr_data    [NUM_LANES],
   output logic     done_vld   [NUM_LANES],
   output rob_idx_t done_idx   [NUM_LANES],
   output data_t    done_data  [NUM_LANES]
);

   logic  wb_vld     [NUM_LANES];
   data_t wb_result  [NUM_LANES];
   logic  wb_reg_wrt [NUM_LANES];

   always_ff @(posedge clk) begin
      for (int l = 0; l < NUM_LANES; l++) begin
         if (reset) begin
            wb_vld[l] <= 1'b0;
         end else if (!stall) begin
            wb_vld[l] <= ex_vld[l];
         end
         if (!stall) begin
            wb_result[l]  <= ex_result[l];
            wb_reg_wrt[l] <= ex_reg_wrt[l];
            wr_preg[l]    <= ex_dst[l];
            done_idx[l]   <= ex_idx[l];
         end
      end
   end

   // completion and register update only in an unstalled cycle
   always_comb begin
      for (int l = 0; l < NUM_LANES; l++) begin
         done_vld[l]  = wb_vld[l] && !stall;
         wr_en[l]     = wb_vld[l] && wb_reg_wrt[l] && !stall;
         wr_data[l]   = wb_result[l];
         done_data[l] = wb_result[l];
      end
   end

endmodule

/* looper_backend.f */
hw/looper_pkg.sv
hw/phys_reg_file.sv
hw/operand_read.sv
hw/alu_lane.sv
hw/writeback.sv
hw/looper_backend.sv
sim/looper_backend_tb.sv

/* sim/looper_backend_tb.sv */
`timescale 1ns/1ns

module looper_backend_tb import looper_pkg::*; ();

   localparam int    MAX_ROWS  = 64;
   localparam string STIM_FILE = "sim/looper_stimulus.txt";

   logic      clk;
   logic      reset;
   logic      stall;
   logic      issue_vld     [NUM_LANES];
   alu_mode_t issue_mode    [NUM_LANES];
   preg_t     issue_src1    [NUM_LANES];
   preg_t     issue_src2    [NUM_LANES];
   data_t     issue_imm     [NUM_LANES];
   logic      issue_imm_vld [NUM_LANES];
   preg_t     issue_dst     [NUM_LANES];
   logic      issue_reg_wrt [NUM_LANES];
   rob_idx_t  issue_idx     [NUM_LANES];
   logic      done_vld      [NUM_LANES];
   rob_idx_t  done_idx      [NUM_LANES];
   data_t     done_data     [NUM_LANES];

   // one row per I line of the stimulus file
   logic      row_stall   [MAX_ROWS];
   logic      row_vld     [MAX_ROWS][NUM_LANES];
   alu_mode_t row_mode    [MAX_ROWS][NUM_LANES];
   preg_t     row_src1    [MAX_ROWS][NUM_LANES];
   preg_t     row_src2    [MAX_ROWS][NUM_LANES];
   data_t     row_imm     [MAX_ROWS][NUM_LANES];
   logic      row_imm_vld [MAX_ROWS][NUM_LANES];
   preg_t     row_dst     [MAX_ROWS][NUM_LANES];
   logic      row_reg_wrt [MAX_ROWS][NUM_LANES];
   rob_idx_t  row_idx     [MAX_ROWS][NUM_LANES];
   int        num_rows = 0;

   // expected completions, oldest first in each lane
   rob_idx_t  exp_idx_q  [NUM_LANES][$];
   data_t     exp_data_q [NUM_LANES][$];
   string     exp_name_q [NUM_LANES][$];

   int mismatch_errors   = 0;
   int unexpected_errors = 0;
   int missing_errors    = 0;
   int timeout_errors    = 0;
   int stimulus_errors   = 0;
   int cycle_count       = 0;
   int cycle_limit       = 0;

   looper_backend looper_backend_inst (
      .clk           (clk),
      .reset         (reset),
      .stall         (stall),
      .issue_vld     (issue_vld),
      .issue_mode    (issue_mode),
      .issue_src1    (issue_src1),
      .issue_src2    (issue_src2),
      .issue_imm     (issue_imm),
      .issue_imm_vld (issue_imm_vld),
      .issue_dst     (issue_dst),
      .issue_reg_wrt (issue_reg_wrt),
      .issue_idx     (issue_idx),
      .done_vld      (done_vld),
      .done_idx      (done_idx),
      .done_data     (done_data)
   );

   always #10 clk = ~clk;

   task automatic end_run();
      int total;
      for (int l = 0; l < NUM_LANES; l++) begin
         if (exp_idx_q[l].size() != 0) begin
            $display("lane %0d: %0d expected completions never arrived",
                     l, exp_idx_q[l].size());
            missing_errors += exp_idx_q[l].size();
         end
      end
      total = mismatch_errors + unexpected_errors + missing_errors + timeout_errors
              + stimulus_errors;
      $display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d timeout, %0d stimulus",
               mismatch_errors, unexpected_errors, missing_errors, timeout_errors,
               stimulus_errors);
      if (total == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   endtask

   task automatic load_stimulus();
      int    fd;
      int    code;
      int    st, lane, data;
      int    v, m, s1, s2, imm, iv, dst, rw, idx;
      string tag, name, rest;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open stimulus file %s", STIM_FILE);
         stimulus_errors++;
      end else begin
         while (!$feof(fd) && $fscanf(fd, "%s", tag) == 1) begin
            if (tag == "I") begin
               if (num_rows >= MAX_ROWS) begin
                  $display("stimulus file has more than %0d issue rows", MAX_ROWS);
                  stimulus_errors++;
                  break;
               end
               code = $fscanf(fd, "%h", st);
               if (code != 1) begin
                  $display("stimulus issue row %0d has no stall field", num_rows);
                  stimulus_errors++;
               end
               row_stall[num_rows] = st[0];
               for (int l = 0; l < NUM_LANES; l++) begin
                  code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                                 v, m, s1, s2, imm, iv, dst, rw, idx);
                  if (code != 9) begin
                     $display("stimulus issue row %0d lane %0d is incomplete",
                              num_rows, l);
                     stimulus_errors++;
                  end
                  row_vld[num_rows][l]     = v[0];
                  row_mode[num_rows][l]    = alu_mode_t'(m);
                  row_src1[num_rows][l]    = preg_t'(s1);
                  row_src2[num_rows][l]    = preg_t'(s2);
                  row_imm[num_rows][l]     = data_t'(imm);
                  row_imm_vld[num_rows][l] = iv[0];
                  row_dst[num_rows][l]     = preg_t'(dst);
                  row_reg_wrt[num_rows][l] = rw[0];
                  row_idx[num_rows][l]     = rob_idx_t'(idx);
               end
               num_rows++;
            end else if (tag == "E") begin
               code = $fscanf(fd, "%d %h %h %s", lane, idx, data, name);
               if (code != 4 || lane < 0 || lane >= NUM_LANES) begin
                  $display("stimulus expected line after issue row %0d is malformed",
                           num_rows);
                  stimulus_errors++;
               end else begin
                  exp_idx_q[lane].push_back(rob_idx_t'(idx));
                  exp_data_q[lane].push_back(data_t'(data));
                  exp_name_q[lane].push_back(name);
               end
            end else begin
               // comment line
               code = $fgets(rest, fd);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic idle_inputs();
      stall <= 1'b0;
      for (int l = 0; l < NUM_LANES; l++) begin
         issue_vld[l]     <= 1'b0;
         issue_mode[l]    <= MODE_ADD;
         issue_src1[l]    <= '0;
         issue_src2[l]    <= '0;
         issue_imm[l]     <= '0;
         issue_imm_vld[l] <= 1'b0;
         issue_dst[l]     <= '0;
         issue_reg_wrt[l] <= 1'b0;
         issue_idx[l]     <= '0;
      end
   endtask

   task automatic drive_row(input int r);
      stall <= row_stall[r];
      for (int l = 0; l < NUM_LANES; l++) begin
         issue_vld[l]     <= row_vld[r][l];
         issue_mode[l]    <= row_mode[r][l];
         issue_src1[l]    <= row_src1[r][l];
         issue_src2[l]    <= row_src2[r][l];
         issue_imm[l]     <= row_imm[r][l];
         issue_imm_vld[l] <= row_imm_vld[r][l];
         issue_dst[l]     <= row_dst[r][l];
         issue_reg_wrt[l] <= row_reg_wrt[r][l];
         issue_idx[l]     <= row_idx[r][l];
      end
   endtask

   function automatic int pending_count();
      int n;
      n = 0;
      for (int l = 0; l < NUM_LANES; l++) begin
         n += exp_idx_q[l].size();
      end
      return n;
   endfunction

   task automatic check_completion(input int lane);
      rob_idx_t want_idx;
      data_t    want_data;
      string    name;
      if (exp_idx_q[lane].size() == 0) begin
         $display("lane %0d completed idx %h data %h when no completion was expected",
                  lane, done_idx[lane], done_data[lane]);
         unexpected_errors++;
      end else begin
         want_idx  = exp_idx_q[lane].pop_front();
         want_data = exp_data_q[lane].pop_front();
         name      = exp_name_q[lane].pop_front();
         if (done_idx[lane] !== want_idx) begin
            $display("MISMATCH %s lane %0d idx: expected %h actual %h",
                     name, lane, want_idx, done_idx[lane]);
            mismatch_errors++;
         end
         if (done_data[lane] !== want_data) begin
            $display("MISMATCH %s lane %0d data: expected %h actual %h",
                     name, lane, want_data, done_data[lane]);
            mismatch_errors++;
         end
      end
   endtask

   // done outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            if (done_vld[l]) begin
               check_completion(l);
            end
         end
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         cycle_count <= 0;
      end else begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            timeout_errors++;
            end_run();
         end
      end
   end

   initial begin
      clk = 1'b0;
      reset <= 1'b1;
      idle_inputs();
      load_stimulus();
      cycle_limit = num_rows + 20;
      if (stimulus_errors != 0) begin
         end_run();
      end else begin
         repeat (2) @(posedge clk);
         reset <= 1'b0;
         for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            drive_row(r);
         end
         @(posedge clk);
         idle_inputs();
         while (pending_count() != 0) begin
            @(posedge clk);
         end
         // one more trip through the three stages for stray completions
         repeat (3) @(posedge clk);
         end_run();
      end
   end

endmodule

/* sim/looper_stimulus.txt */
# I stall, then per lane: vld mode src1 src2 imm imm_vld dst reg_wrt idx (hex)
# E lane idx data name: expected completion, in order within its lane
I 0 1 7 00 05 0000 0 00 0 01 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 01 0000 reset_read
I 0 1 7 00 00 1234 1 01 1 02 1 7 00 00 00f0 1 02 1 03 1 7 00 00 0003 1 03 1 04 1 7 00 00 a5a5 1 04 1 05
E 0 02 1234 load_imm
E 1 03 00f0 load_imm
E 2 04 0003 load_imm
E 3 05 a5a5 load_imm
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
I 0 1 0 01 02 0000 0 05 1 06 1 1 01 04 0000 0 06 1 07 1 2 04 02 0000 0 07 1 08 1 3 02 03 0000 0 08 1 09
E 0 06 1324 add_reg
E 1 07 6c8f sub_reg
E 2 08 00a0 and_reg
E 3 09 00f3 or_reg
I 0 1 4 01 04 0000 0 09 1 0a 1 5 02 03 0000 0 0a 1 0b 1 6 04 03 0000 0 0b 1 0c 1 7 00 01 0000 0 0c 1 0d
E 0 0a b791 xor_reg
E 1 0b 0780 sll_reg
E 2 0c 14b4 srl_reg
E 3 0d 1234 pass_reg
I 0 1 0 04 00 ffff 1 0d 1 0e 1 1 03 00 0004 1 0e 1 0f 1 2 01 00 0ff0 1 0f 1 10 1 3 02 00 8001 1 10 1 11
E 0 0e a5a4 add_imm
E 1 0f ffff sub_imm
E 2 10 0230 and_imm
E 3 11 80f1 or_imm
I 0 1 4 04 00 ffff 1 11 1 12 1 5 01 00 0014 1 12 1 13 1 6 01 00 0018 1 13 1 14 1 7 00 01 beef 1 14 1 15
E 0 12 5a5a xor_imm
E 1 13 2340 sll_imm
E 2 14 0012 srl_imm
E 3 15 beef pass_imm
I 0 1 0 09 05 0000 0 15 1 16 1 1 0a 0b 0000 0 16 1 17 1 7 00 00 7777 1 01 0 18 0 0 0 0 0 0 0 0 0
E 0 16 cab5 bypass_add
E 1 17 f2cc bypass_sub
E 2 18 7777 no_write
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
I 0 0 0 0 0 0 0 0 0 0 1 7 00 01 0000 0 17 1 19 0 0 0 0 0 0 0 0 0 1 0 0d 10 0000 0 18 1 1a
E 1 19 1234 no_write_read
E 3 1a 2695 regfile_add
I 0 1 7 00 00 0101 1 20 1 1b 1 7 00 00 0202 1 21 1 1c 1 7 00 00 0303 1 22 1 1d 1 7 00 00 0404 1 23 1 1e
E 0 1b 0101 stall_wb
E 1 1c 0202 stall_wb
E 2 1d 0303 stall_wb
E 3 1e 0404 stall_wb
I 0 1 0 02 00 0010 1 24 1 1f 1 1 04 03 0000 0 25 1 20 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 1f 0100 stall_ex
E 1 20 a5a2 stall_ex
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 01 00 00ff 1 26 1 21 1 2 04 01 0000 0 27 1 22
E 2 21 12cb stall_op
E 3 22 0024 stall_op
I 1 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f
I 1 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f
I 1 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f 1 7 00 00 dead 1 3f 1 3f
I 0 1 0 20 23 0000 0 28 1 23 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 23 0505 stall_bypass
